/* Makefile */
TOP = dcu_sb_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f files.f

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "=== FAIL ===" sim.log; then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

/* files.f */
+incdir+hw
hw/dcu_sb_pkg.sv
hw/dcu_sb_ent.sv
hw/dcu_sb_drain_arb.sv
hw/dcu_sb.sv
sim/dcu_sb_properties.sv
sim/dcu_sb_tb.sv

/* hw/dcu_sb.sv */
// store buffer top with entry array, free search, forward and drain muxing, status
`timescale 1ns/100ps
`include "dcu_sb_defines.svh"

module dcu_sb (
    input  logic                  dcu_clk,
    input  logic                  reset,
    input  dcu_sb_pkg::sb_enq_t   enq,
    output logic [`SB_DEPTH-1:0]  enq_free_ptr,
    input  dcu_sb_pkg::sb_cmt_t   cmt,
    input  dcu_sb_pkg::sb_addr_u  cmp_addr,
    output dcu_sb_pkg::sb_fwd_t   fwd,
    output logic                  drain_valid,
    output dcu_sb_pkg::sb_drain_t drain,
    input  logic                  drain_ready,
    output logic                  empty,
    output logic                  full,
    output logic                  afull,
    output logic [`SB_DEPTH-1:0]  pending
);

    logic [`SB_DEPTH-1:0] ent_valid;
    logic [`SB_DEPTH-1:0] ent_pending;
    logic [`SB_DEPTH-1:0] drain_req;
    logic [`SB_DEPTH-1:0] word_hit;
    logic [`SB_DEPTH-1:0] line_hit;
    logic [`SB_DEPTH-1:0] enq_tgt;
    logic [`SB_DEPTH-1:0] enq_stb;
    logic [`SB_DEPTH-1:0] cmt_stb;
    logic [`SB_DEPTH-1:0] drain_ack;
    logic [`SB_DEPTH-1:0] grant;
    logic                 advance;

    dcu_sb_pkg::sb_ent_t [`SB_DEPTH-1:0] ent_vec;
    dcu_sb_pkg::sb_ent_t                 fwd_sel;
    dcu_sb_pkg::sb_ent_t                 drain_sel;

    // one-hot select over the entry contents, zero when nothing is selected
    function automatic dcu_sb_pkg::sb_ent_t ent_mux(
        input logic [`SB_DEPTH-1:0]                sel,
        input dcu_sb_pkg::sb_ent_t [`SB_DEPTH-1:0] ents
    );
        dcu_sb_pkg::sb_ent_t r;
        r = '0;
        for (int i = 0; i < `SB_DEPTH; i++) begin
            r = r | (ents[i] & {$bits(dcu_sb_pkg::sb_ent_t){sel[i]}});
        end
        return r;
    endfunction

    // lowest clear bit of the valid vector, zero when full
    assign enq_free_ptr = ~ent_valid & (ent_valid + 1'b1);

    assign enq_tgt   = enq.mrg ? enq.mrg_ptr : enq_free_ptr;
    assign enq_stb   = {`SB_DEPTH{enq.valid}} & enq_tgt;
    assign cmt_stb   = {`SB_DEPTH{cmt.valid}} & cmt.ptr;
    assign drain_ack = {`SB_DEPTH{drain_ready}} & grant;

    for (genvar i = 0; i < `SB_DEPTH; i++) begin : g_ent
        dcu_sb_ent ent_i (
            .dcu_clk   (dcu_clk),
            .reset     (reset),
            .enq_valid (enq_stb[i]),
            .enq       (enq),
            .cmt_valid (cmt_stb[i]),
            .cmt       (cmt),
            .drain_ack (drain_ack[i]),
            .cmp_addr  (cmp_addr),
            .valid     (ent_valid[i]),
            .pending   (ent_pending[i]),
            .drain_req (drain_req[i]),
            .word_hit  (word_hit[i]),
            .line_hit  (line_hit[i]),
            .ent       (ent_vec[i])
        );
    end

    assign drain_valid = |drain_req;
    assign advance     = drain_valid & drain_ready;

    dcu_sb_drain_arb drain_arb_i (
        .dcu_clk (dcu_clk),
        .reset   (reset),
        .advance (advance),
        .req     (drain_req),
        .grant   (grant)
    );

    // forward path, merging keeps word hits to one entry at most
    assign fwd_sel = ent_mux(word_hit, ent_vec);

    assign fwd.hit          = |word_hit;
    assign fwd.hit_ptr      = word_hit;
    assign fwd.hit_line_ptr = line_hit;
    assign fwd.rdata        = fwd_sel.data;
    assign fwd.rmask        = fwd_sel.mask;

    assign drain_sel = ent_mux(grant, ent_vec);   // payload of the granted entry

    assign drain.addr = drain_sel.addr;
    assign drain.way  = drain_sel.way;
    assign drain.data = drain_sel.data;
    assign drain.mask = drain_sel.mask;

    assign full    = &ent_valid;
    assign empty   = ~|ent_valid;
    assign afull   = $onehot(~ent_valid);          // exactly one free slot
    assign pending = ent_pending;

endmodule

/* hw/dcu_sb_defines.svh */
// store buffer depth, address width, way count and line geometry
`ifndef DCU_SB_DEFINES_SVH
`define DCU_SB_DEFINES_SVH

`define SB_DEPTH      4     // entries, also the width of every one-hot pointer
`define SB_PALEN      32
`define SB_WAYS       4     // way travels one-hot
`define SB_LINE_OFS   6     // 64-byte line
`define SB_WORD_OFS   2

// derived word and line fields
`define SB_WORD_BYTES (1 << `SB_WORD_OFS)
`define SB_WORD_W     (8 * `SB_WORD_BYTES)
`define SB_TAG_W      (`SB_PALEN - `SB_LINE_OFS)
`define SB_WIDX_W     (`SB_LINE_OFS - `SB_WORD_OFS)

`endif

/* hw/dcu_sb_drain_arb.sv */
// round-robin drain arbiter whose priority moves only on a drain handshake
`timescale 1ns/100ps
`include "dcu_sb_defines.svh"

module dcu_sb_drain_arb (
    input  logic                 dcu_clk,
    input  logic                 reset,
    input  logic                 advance,
    input  logic [`SB_DEPTH-1:0] req,
    output logic [`SB_DEPTH-1:0] grant
);

    localparam int PW = (`SB_DEPTH > 1) ? $clog2(`SB_DEPTH) : 1;

    logic [PW-1:0]        prio_q;     // first entry looked at
    logic [PW-1:0]        gnt_idx;
    logic [`SB_DEPTH-1:0] rr_grant;
    logic [`SB_DEPTH-1:0] grant_q;
    logic                 lock_q;     // last grant was not accepted
    logic                 hold;

    // first requester at or after the priority position
    always_comb begin
        int   idx;
        logic found;
        rr_grant = '0;
        found    = 1'b0;
        for (int i = 0; i < `SB_DEPTH; i++) begin
            idx = (int'(prio_q) + i) % `SB_DEPTH;
            if (!found && req[idx]) begin
                found         = 1'b1;
                rr_grant[idx] = 1'b1;
            end
        end
    end

    // a stalled grant sticks even if an entry ahead of it starts requesting
    assign hold  = lock_q & |(grant_q & req);
    assign grant = hold ? grant_q : rr_grant;

    always_comb begin
        gnt_idx = '0;
        for (int i = 0; i < `SB_DEPTH; i++) begin
            if (grant[i]) begin
                gnt_idx = PW'(i);
            end
        end
    end

    always_ff @(posedge dcu_clk) begin
        if (reset) begin
            prio_q  <= '0;
            lock_q  <= 1'b0;
            grant_q <= '0;
        end else begin
            lock_q  <= |req & ~advance;
            grant_q <= grant;
            if (advance) begin
                prio_q <= (int'(gnt_idx) == `SB_DEPTH - 1) ? '0 : gnt_idx + 1'b1;
            end
        end
    end

endmodule

/* hw/dcu_sb_ent.sv */
// store buffer entry holding one word store and its valid/pending/committed state
`timescale 1ns/100ps
`include "dcu_sb_defines.svh"

module dcu_sb_ent (
    input  logic                 dcu_clk,
    input  logic                 reset,
    input  logic                 enq_valid,
    input  dcu_sb_pkg::sb_enq_t  enq,
    input  logic                 cmt_valid,
    input  dcu_sb_pkg::sb_cmt_t  cmt,
    input  logic                 drain_ack,
    input  dcu_sb_pkg::sb_addr_u cmp_addr,
    output logic                 valid,
    output logic                 pending,
    output logic                 drain_req,
    output logic                 word_hit,
    output logic                 line_hit,
    output dcu_sb_pkg::sb_ent_t  ent
);

    logic                      valid_q;
    logic                      pending_q;      // enqueued, waiting for commit
    logic                      cmtd_q;         // data written at least once
    dcu_sb_pkg::sb_addr_u      addr_q;
    logic [`SB_WAYS-1:0]       way_q;
    logic [`SB_WORD_W-1:0]     data_q;
    logic [`SB_WORD_BYTES-1:0] mask_q;

    logic alloc;       // fresh allocation
    logic cmt_write;   // commit that keeps the store

    assign alloc     = enq_valid & ~enq.mrg;
    assign cmt_write = cmt_valid & ~cmt.kill;

    // state flags, later rules in the block take priority
    always_ff @(posedge dcu_clk) begin
        if (reset) begin
            valid_q   <= 1'b0;
            pending_q <= 1'b0;
            cmtd_q    <= 1'b0;
        end else begin
            if (drain_ack) begin
                valid_q <= 1'b0;     // written to the cache, entry free
                cmtd_q  <= 1'b0;
            end

            if (cmt_valid) begin
                pending_q <= 1'b0;
                if (cmt.kill) begin
                    valid_q <= 1'b0; // speculative store cancelled
                    cmtd_q  <= 1'b0;
                end else begin
                    cmtd_q <= 1'b1;
                end
            end

            if (enq_valid) begin
                // a merge only reopens the entry, it blocks drain until the next commit
                pending_q <= 1'b1;
                if (!enq.mrg) begin
                    valid_q <= 1'b1;
                    cmtd_q  <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge dcu_clk) begin
        if (alloc) begin
            addr_q <= enq.addr;
            way_q  <= enq.way;
            data_q <= '0;
            mask_q <= '0;
        end else if (cmt_write) begin
            // byte merge, unmasked bytes keep the older store
            for (int b = 0; b < `SB_WORD_BYTES; b++) begin
                if (cmt.wmask[b]) begin
                    data_q[8*b +: 8] <= cmt.wdata[8*b +: 8];
                end
            end
            mask_q <= mask_q | cmt.wmask;
        end
    end

    // word compare on the flat view, byte offset dropped
    assign word_hit = valid_q &
        (addr_q.flat[`SB_PALEN-1:`SB_WORD_OFS] == cmp_addr.flat[`SB_PALEN-1:`SB_WORD_OFS]);

    assign line_hit = valid_q & (addr_q.fld.tag == cmp_addr.fld.tag);   // tag only

    assign drain_req = valid_q & cmtd_q & ~pending_q;

    assign valid   = valid_q;
    assign pending = pending_q;

    assign ent.addr = addr_q.flat;
    assign ent.way  = way_q;
    assign ent.data = data_q;
    assign ent.mask = mask_q;

endmodule

/* hw/dcu_sb_pkg.sv */
// store buffer bundle types for enqueue, commit, forward and drain
`include "dcu_sb_defines.svh"

package dcu_sb_pkg;

    typedef struct packed {
        logic [`SB_TAG_W-1:0]    tag;
        logic [`SB_WIDX_W-1:0]   widx;     // word in line
        logic [`SB_WORD_OFS-1:0] bofs;
    } sb_addr_fld_t;

    // same address word, flat for word compare and drain, split for line compare
    typedef union packed {
        logic [`SB_PALEN-1:0] flat;
        sb_addr_fld_t         fld;
    } sb_addr_u;

    typedef struct packed {
        logic                 valid;
        logic                 mrg;
        logic [`SB_DEPTH-1:0] mrg_ptr;
        sb_addr_u             addr;
        logic [`SB_WAYS-1:0]  way;
    } sb_enq_t;

    typedef struct packed {
        logic                     valid;
        logic                     kill;
        logic [`SB_DEPTH-1:0]     ptr;
        logic [`SB_WORD_W-1:0]    wdata;
        logic [`SB_WORD_BYTES-1:0] wmask;
    } sb_cmt_t;

    typedef struct packed {
        logic                     hit;
        logic [`SB_DEPTH-1:0]     hit_ptr;
        logic [`SB_DEPTH-1:0]     hit_line_ptr;
        logic [`SB_WORD_W-1:0]    rdata;
        logic [`SB_WORD_BYTES-1:0] rmask;
    } sb_fwd_t;

    typedef struct packed {
        logic [`SB_PALEN-1:0]     addr;
        logic [`SB_WAYS-1:0]      way;
        logic [`SB_WORD_W-1:0]    data;
        logic [`SB_WORD_BYTES-1:0] mask;
    } sb_drain_t;

    typedef struct packed {
        logic [`SB_PALEN-1:0]     addr;
        logic [`SB_WAYS-1:0]      way;
        logic [`SB_WORD_W-1:0]    data;
        logic [`SB_WORD_BYTES-1:0] mask;
    } sb_ent_t;

endpackage

/* sim/dcu_sb_properties.sv */
// store buffer assertions on drain stability, status flags and arbiter grant
`timescale 1ns/100ps
`include "dcu_sb_defines.svh"

module dcu_sb_properties (
    input logic                  dcu_clk,
    input logic                  reset,
    input dcu_sb_pkg::sb_enq_t   enq,
    input logic                  drain_valid,
    input logic                  drain_ready,
    input dcu_sb_pkg::sb_drain_t drain,
    input logic                  full,
    input logic                  empty,
    input logic [`SB_DEPTH-1:0]  grant
);

    logic mrg_now;

    assign mrg_now = enq.valid & enq.mrg;   // a merge may pull the granted entry back

    drain_stall_hold: assert property (@(posedge dcu_clk) disable iff (reset)
        drain_valid && !drain_ready && !mrg_now |=> drain_valid && $stable(drain))
        else $error("drain valid or payload changed while drain_ready was low");

    full_empty_excl: assert property (@(posedge dcu_clk) disable iff (reset)
        !(full && empty))
        else $error("full and empty both high");

    grant_onehot: assert property (@(posedge dcu_clk) disable iff (reset)
        $onehot0(grant))
        else $error("drain grant has more than one bit set");

endmodule

bind dcu_sb dcu_sb_properties props_i (
    .dcu_clk     (dcu_clk),
    .reset       (reset),
    .enq         (enq),
    .drain_valid (drain_valid),
    .drain_ready (drain_ready),
    .drain       (drain),
    .full        (full),
    .empty       (empty),
    .grant       (grant)
);

/* sim/dcu_sb_stimulus.txt */
# op  f1..f7 in hex; enq: addr way 0 0, mrg: ptr 0 0 0, cmt/kill: ptr wdata wmask 0
# drain: addr way data mask; f5 f6 f7 = free ptr, {empty,afull,full}, pending after the op
# cmp: addr hit hit_ptr line_ptr rdata rmask 0
# fill all four entries in order
enq   00001000 1        0        0        2        0 1
enq   00001008 2        0        0        4        0 3
enq   00002040 4        0        0        8        2 7
enq   00003000 8        0        0        0        1 f
# commit entry 0, then compare same word, same line and unrelated address
cmt   1        11223344 f        0        0        1 e
cmp   00001002 1        1        3        11223344 f 0
cmp   0000100c 0        0        3        0        0 0
cmp   00005000 0        0        0        0        0 0
cmt   2        aabbccdd 3        0        0        1 c
cmp   00001008 1        2        3        0000ccdd 3 0
# merge into entry 1, second commit fills the upper bytes
mrg   2        0        0        0        0        1 e
cmt   2        55667788 c        0        0        1 c
cmp   00001009 1        2        3        5566ccdd f 0
# kill entry 2, next enqueue takes it again
kill  4        0        0        0        4        2 8
enq   00004000 2        0        0        0        1 c
cmp   00002040 0        0        0        0        0 0
cmt   4        01020304 5        0        0        1 8
cmt   8        deadbeef 8        0        0        1 0
# drain under random back-pressure
drain 00001000 1        11223344 f        1        2 0
drain 00001008 2        5566ccdd f        1        0 0
# entry 0 refilled, drains after entries 2 and 3 by round-robin
enq   00006010 4        0        0        2        2 1
cmt   1        cafef00d f        0        2        2 0
cmp   00006013 1        1        1        cafef00d f 0
drain 00004000 2        00020004 5        2        0 0
drain 00003000 8        de000000 8        2        0 0
drain 00006010 4        cafef00d f        1        4 0

/* sim/dcu_sb_tb.sv */
// store buffer testbench driving file-based enqueue, commit, compare and drain operations
`timescale 1ns/100ps
`include "dcu_sb_defines.svh"

module dcu_sb_tb;

    logic                  dcu_clk = 1'b0;
    logic                  reset;
    dcu_sb_pkg::sb_enq_t   enq;
    logic [`SB_DEPTH-1:0]  enq_free_ptr;
    dcu_sb_pkg::sb_cmt_t   cmt;
    dcu_sb_pkg::sb_addr_u  cmp_addr;
    dcu_sb_pkg::sb_fwd_t   fwd;
    logic                  drain_valid;
    dcu_sb_pkg::sb_drain_t drain;
    logic                  drain_ready;
    logic                  empty;
    logic                  full;
    logic                  afull;
    logic [`SB_DEPTH-1:0]  pending;

    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;
    int     max_cycles = 0;     // known after the first pass over the file
    integer seed = 17;

    dcu_sb dut_i (
        .dcu_clk      (dcu_clk),
        .reset        (reset),
        .enq          (enq),
        .enq_free_ptr (enq_free_ptr),
        .cmt          (cmt),
        .cmp_addr     (cmp_addr),
        .fwd          (fwd),
        .drain_valid  (drain_valid),
        .drain        (drain),
        .drain_ready  (drain_ready),
        .empty        (empty),
        .full         (full),
        .afull        (afull),
        .pending      (pending)
    );

    always #5 dcu_clk = ~dcu_clk;

    always @(posedge dcu_clk) begin
        cycles <= cycles + 1;
        if (max_cycles > 0 && cycles >= max_cycles) begin
            $display("timeout: stimulus not finished after %0d cycles", cycles);
            $display("checks: %0d errors: %0d", checks, errors + 1);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // stat is {empty, afull, full}
    task automatic check_state(input logic [31:0] free, input logic [31:0] stat,
                               input logic [31:0] pend);
        check_value("enq_free_ptr", enq_free_ptr, free);
        check_value("status", {29'd0, empty, afull, full}, stat);
        check_value("pending", pending, pend);
    endtask

    task automatic enqueue_store(input logic [31:0] addr, input logic [31:0] way,
                                 input logic mrg, input logic [31:0] ptr);
        dcu_sb_pkg::sb_enq_t e;
        e           = '0;
        e.valid     = 1'b1;
        e.mrg       = mrg;
        e.mrg_ptr   = ptr[`SB_DEPTH-1:0];
        e.addr.flat = addr;
        e.way       = way[`SB_WAYS-1:0];
        @(posedge dcu_clk);
        enq <= e;
        @(posedge dcu_clk);
        enq <= '0;
        @(negedge dcu_clk);
    endtask

    task automatic commit_store(input logic [31:0] ptr, input logic [31:0] wdata,
                                input logic [31:0] wmask, input logic kill);
        dcu_sb_pkg::sb_cmt_t c;
        c       = '0;
        c.valid = 1'b1;
        c.kill  = kill;
        c.ptr   = ptr[`SB_DEPTH-1:0];
        c.wdata = wdata;
        c.wmask = wmask[`SB_WORD_BYTES-1:0];
        @(posedge dcu_clk);
        cmt <= c;
        @(posedge dcu_clk);
        cmt <= '0;
        @(negedge dcu_clk);
    endtask

    task automatic compare_load(input logic [31:0] addr, hit, hptr, lptr, rdata, rmask);
        @(posedge dcu_clk);
        cmp_addr.flat <= addr;
        @(negedge dcu_clk);     // fwd is combinational from cmp_addr
        check_value("fwd.hit", fwd.hit, hit);
        check_value("fwd.hit_ptr", fwd.hit_ptr, hptr);
        check_value("fwd.hit_line_ptr", fwd.hit_line_ptr, lptr);
        check_value("fwd.rdata", fwd.rdata, rdata);
        check_value("fwd.rmask", fwd.rmask, rmask);
    endtask

    // random ready until one transfer is seen, payload checked in the accepting cycle
    task automatic drain_one(input logic [31:0] addr, way, data, mask);
        logic [31:0] rnd;
        logic        taken;
        taken = 1'b0;
        while (!taken) begin
            @(posedge dcu_clk);
            rnd = $random(seed);
            drain_ready <= rnd[0];
            @(negedge dcu_clk);
            if (drain_valid && drain_ready) begin
                taken = 1'b1;
                check_value("drain.addr", drain.addr, addr);
                check_value("drain.way", drain.way, way);
                check_value("drain.data", drain.data, data);
                check_value("drain.mask", drain.mask, mask);
            end
        end
        @(posedge dcu_clk);
        drain_ready <= 1'b0;
        @(negedge dcu_clk);
    endtask

    initial begin
        integer           fd;
        integer           code;
        int               n_ops;
        logic             done;
        logic             state_op;
        logic [8*8-1:0]   op;
        logic [8*256-1:0] rest;
        logic [31:0]      fld [1:7];

        reset       = 1'b1;
        enq         = '0;
        cmt         = '0;
        cmp_addr    = '0;
        drain_ready = 1'b0;

        // first pass counts operations
        n_ops = 0;
        fd = $fopen("sim/dcu_sb_stimulus.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open the stimulus file sim/dcu_sb_stimulus.txt");
        end else begin
            done = 1'b0;
            while (!done) begin
                code = $fscanf(fd, "%s", op);
                if (code != 1) begin
                    done = 1'b1;
                end else begin
                    if (op != "#") begin
                        n_ops++;
                    end
                    code = $fgets(rest, fd);
                end
            end
            $fclose(fd);
        end
        max_cycles = 20 * n_ops;

        repeat (2) @(posedge dcu_clk);
        reset <= 1'b0;
        @(negedge dcu_clk);
        check_value("drain_valid after reset", drain_valid, 32'h0);
        check_state(32'h1, 32'h4, 32'h0);

        if (n_ops > 0) begin
            fd = $fopen("sim/dcu_sb_stimulus.txt", "r");
            done = 1'b0;
            while (!done) begin
                code = $fscanf(fd, "%s", op);
                if (code != 1) begin
                    done = 1'b1;
                end else if (op == "#") begin
                    code = $fgets(rest, fd);      // comment line
                end else begin
                    code = $fscanf(fd, "%h %h %h %h %h %h %h",
                                   fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7]);
                    if (code != 7) begin
                        errors++;
                        $display("stimulus line for %0s has %0d fields instead of 7", op, code);
                        done = 1'b1;
                    end else begin
                        state_op = 1'b1;
                        case (op)
                            "enq":   enqueue_store(fld[1], fld[2], 1'b0, 32'h0);
                            "mrg":   enqueue_store(32'h0, 32'h0, 1'b1, fld[1]);
                            "cmt":   commit_store(fld[1], fld[2], fld[3], 1'b0);
                            "kill":  commit_store(fld[1], 32'h0, 32'h0, 1'b1);
                            "drain": drain_one(fld[1], fld[2], fld[3], fld[4]);
                            "cmp": begin
                                compare_load(fld[1], fld[2], fld[3], fld[4], fld[5], fld[6]);
                                state_op = 1'b0;
                            end
                            default: begin
                                errors++;
                                $display("unknown operation %0s in the stimulus file", op);
                                state_op = 1'b0;
                            end
                        endcase
                        if (state_op) begin
                            check_state(fld[5], fld[6], fld[7]);
                        end
                    end
                end
            end
            $fclose(fd);
        end

        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
